//--- tb.f
+incdir+rtl
rtl/pcm_pkg.sv
rtl/i2s_pkg.sv
rtl/pcm_fifo.sv
rtl/i2s_tx.sv
rtl/underrun_monitor.sv
rtl/audio_out_top.sv
sim/audio_out_properties.sv
sim/audio_out_tb.sv

//--- sim/audio_out_tb.sv
`timescale 1ns/100ps
`include "audio_config.svh"

module audio_out_tb;
    import pcm_pkg::*;
    import i2s_pkg::*;

    localparam int FIFO_DEPTH   = 1 << `PCM_FIFO_DEPTH_LOG2;
    localparam int FRAME_CLOCKS = 2 * PCM_WORD_BITS * 2 * `AUDIO_CLK_DIVISOR;
    localparam int MAX_CYCLES   = 52 * FRAME_CLOCKS; // Traffic needs about 35 frame periods

    logic                          clk_i;
    logic                          rst_i;
    logic                          pcm_wr_i;
    pcm_frame_t                    pcm_data_i;
    logic                          pcm_full_o;
    logic [`PCM_FIFO_DEPTH_LOG2:0] pcm_level_o;
    logic                          ur_clear_i;
    logic [`UR_COUNT_WIDTH-1:0]    ur_count_o;
    logic                          ur_flag_o;
    logic                          bclk_o;
    logic                          ws_o;
    logic                          data_o;

    pcm_frame_t                 ref_q[$]; // Frames the buffer accepted, oldest first
    pcm_frame_t                 exp_q[$]; // Frames the serial stream should carry
    pcm_frame_t                 last_exp;
    logic [`UR_COUNT_WIDTH-1:0] ur_model;
    logic                       flag_model;
    logic                       bclk_prev;
    logic                       clr_prev;
    logic                       ur_hit;
    int                         size_at_fetch;
    int                         fall_n; // Bit clock falls since the last fetch
    int                         errors = 0;
    int                         frames_checked = 0;
    int                         ur_seen = 0;
    int                         cycles = 0;
    int unsigned                seed_val;
    i2s_slot_e                  prev_ws = SLOT_RIGHT;
    i2s_slot_e                  last_ch = SLOT_RIGHT;
    i2s_slot_e                  ch;
    pcm_word_t                  shift_word = '0;
    pcm_word_t                  left_word = '0;
    int                         bit_n = 0;

    audio_out_top dut
    (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .pcm_wr_i    (pcm_wr_i),
        .pcm_data_i  (pcm_data_i),
        .pcm_full_o  (pcm_full_o),
        .pcm_level_o (pcm_level_o),
        .ur_clear_i  (ur_clear_i),
        .ur_count_o  (ur_count_o),
        .ur_flag_o   (ur_flag_o),
        .bclk_o      (bclk_o),
        .ws_o        (ws_o),
        .data_o      (data_o)
    );

    bind i2s_tx audio_out_properties props
    (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .pcm_fifo_empty_i (pcm_fifo_empty_i),
        .pcm_fifo_rd_o    (pcm_fifo_rd_o),
        .pcm_fifo_ur_o    (pcm_fifo_ur_o),
        .bclk_o           (bclk_o),
        .ws_o             (ws_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else
        begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Back-to-back writes with random frames
    task automatic write_frames(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            @(posedge clk_i);
            pcm_wr_i   <= 1'b1;
            pcm_data_i <= pcm_frame_t'($urandom());
        end
        @(posedge clk_i);
        pcm_wr_i <= 1'b0;
    endtask

    // Keeps the buffer partly filled so the stream never starves
    task automatic stream_frames(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            @(negedge clk_i);
            while (pcm_level_o >= 8)
            begin
                @(negedge clk_i);
            end
            write_frames(1);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int total;
        total = errors + dut.u_tx.props.fail_count;
        $display("Frames checked %0d, underruns %0d, testbench errors %0d, assertion failures %0d",
                 frames_checked, ur_seen, errors, dut.u_tx.props.fail_count);
        if (!timed_out && total == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Buffer and monitor model, sampled mid-cycle where every output is settled
    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            ref_q.delete();
            exp_q.delete();
            exp_q.push_back('0); // Held frame is zero out of reset and plays first
            last_exp      = '0;
            ur_model      = '0;
            flag_model    = 1'b0;
            bclk_prev     = 1'b0;
            clr_prev      = 1'b0;
            size_at_fetch = 0;
            fall_n        = 0;
        end
        else
        begin
            ur_hit = 1'b0;
            if (bclk_prev && !bclk_o)
            begin
                if (fall_n == 0)
                begin
                    ur_hit = (size_at_fetch == 0); // Fetch saw the level from before this edge
                    if (!ur_hit)
                    begin
                        last_exp = ref_q.pop_front();
                    end
                    exp_q.push_back(last_exp);
                end
                fall_n = (fall_n + 1) % I2S_BITS_PER_FRAME; // Only bit 0 of a left word fetches
            end
            if (ur_hit)
            begin
                ur_seen++;
            end
            if (clr_prev)
            begin
                ur_model   = '0;
                flag_model = 1'b0;
            end
            else if (ur_hit)
            begin
                flag_model = 1'b1;
                if (ur_model != '1)
                begin
                    ur_model = ur_model + 1'b1;
                end
            end
            check_value("ur_count_o", ur_count_o, ur_model);
            check_value("ur_flag_o", ur_flag_o, flag_model);
            check_value("pcm_level_o", pcm_level_o, ref_q.size());
            check_value("pcm_full_o", pcm_full_o, ref_q.size() == FIFO_DEPTH);
            size_at_fetch = ref_q.size();
            if (pcm_wr_i && ref_q.size() < FIFO_DEPTH)
            begin
                ref_q.push_back(pcm_data_i);
            end
            clr_prev  = ur_clear_i;
            bclk_prev = bclk_o;
        end
    end

    // I2S receiver: data lags word select by one bit
    always @(posedge bclk_o)
    begin
        ch = prev_ws;
        if (ch != last_ch)
        begin
            bit_n = 0;
        end
        shift_word = {shift_word[PCM_WORD_BITS-2:0], data_o};
        bit_n++;
        if (bit_n == PCM_WORD_BITS)
        begin
            if (ch == SLOT_LEFT)
            begin
                left_word = shift_word;
            end
            else if (exp_q.size() == 0)
            begin
                errors++;
                $display("Decoder finished a frame at %0t but no frame was expected", $time);
            end
            else
            begin
                check_value("decoded frame", {left_word, shift_word}, exp_q.pop_front());
                frames_checked++;
            end
        end
        last_ch = ch;
        prev_ws = i2s_slot_e'(ws_o);
    end

    always @(posedge clk_i)
    begin
        cycles++;
        if (cycles == MAX_CYCLES)
        begin
            $display("Test did not finish within %0d cycles", MAX_CYCLES);
            finish_run(1'b1);
        end
    end

    initial
    begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        pcm_wr_i   = 1'b0;
        pcm_data_i = '0;
        ur_clear_i = 1'b0;
        seed_val   = $urandom(52902);
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("bclk_o after reset", bclk_o, 1'b0);
        check_value("ws_o after reset", ws_o, 1'b0);
        check_value("data_o after reset", data_o, 1'b0);
        check_value("pcm_level_o after reset", pcm_level_o, 0);
        check_value("ur_count_o after reset", ur_count_o, 0);
        check_value("ur_flag_o after reset", ur_flag_o, 1'b0);

        stream_frames(12);
        wait (ur_count_o >= 2); // Writes have stopped so the buffer drains
        @(negedge clk_i);
        check_value("ur_flag_o after drain", ur_flag_o, 1'b1);

        @(posedge clk_i);
        ur_clear_i <= 1'b1;
        @(posedge clk_i);
        ur_clear_i <= 1'b0;
        @(negedge clk_i);
        check_value("ur_count_o after clear", ur_count_o, 0);
        check_value("ur_flag_o after clear", ur_flag_o, 1'b0);
        wait (ur_flag_o);
        @(negedge clk_i);
        check_value("ur_count_o after new underrun", ur_count_o, 1);

        // Start right after a fetch so no read lands inside the burst
        @(negedge ws_o);
        write_frames(FIFO_DEPTH + 8);
        @(negedge clk_i);
        check_value("pcm_full_o after burst", pcm_full_o, 1'b1);
        check_value("pcm_level_o after burst", pcm_level_o, FIFO_DEPTH);

        while (ref_q.size() != 0)
        begin
            @(negedge clk_i);
        end
        repeat (3) @(negedge ws_o);
        finish_run(1'b0);
    end

endmodule

//--- sim/audio_out_properties.sv
`timescale 1ns/100ps
`include "audio_config.svh"

module audio_out_properties
(
    input logic clk_i,
    input logic rst_i,
    input logic pcm_fifo_empty_i,
    input logic pcm_fifo_rd_o,
    input logic pcm_fifo_ur_o,
    input logic bclk_o,
    input logic ws_o
);

    int fail_count = 0; // Read by the testbench when it closes the run

    rd_single: assert property (@(posedge clk_i) disable iff (rst_i)
        pcm_fifo_rd_o |=> !pcm_fifo_rd_o)
    else
    begin
        $error("Read strobe lasted more than one cycle");
        fail_count++;
    end

    rd_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        pcm_fifo_rd_o |-> !pcm_fifo_empty_i)
    else
    begin
        $error("Read strobe raised while the buffer was empty");
        fail_count++;
    end

    // An underrun is only legal when there is nothing to fetch
    ur_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        pcm_fifo_ur_o |-> pcm_fifo_empty_i)
    else
    begin
        $error("Underrun strobe raised while the buffer held frames");
        fail_count++;
    end

    rd_ur_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(pcm_fifo_rd_o && pcm_fifo_ur_o))
    else
    begin
        $error("Read and underrun strobes were high together");
        fail_count++;
    end

    ws_after_fall: assert property (@(posedge clk_i) disable iff (rst_i)
        $changed(ws_o) |-> $fell(bclk_o))
    else
    begin
        $error("Word select changed away from a bit clock falling edge");
        fail_count++;
    end

    bclk_high_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(bclk_o) |-> bclk_o [*`AUDIO_CLK_DIVISOR] ##1 !bclk_o)
    else
    begin
        $error("Bit clock high level had the wrong length");
        fail_count++;
    end

    bclk_low_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(bclk_o) |-> !bclk_o [*`AUDIO_CLK_DIVISOR] ##1 bclk_o)
    else
    begin
        $error("Bit clock low level had the wrong length");
        fail_count++;
    end

endmodule

//--- rtl/audio_out_top.sv
`timescale 1ns/100ps
`include "audio_config.svh"

module audio_out_top
(
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            pcm_wr_i,
    input  pcm_pkg::pcm_frame_t             pcm_data_i,
    output logic                            pcm_full_o,
    output logic [`PCM_FIFO_DEPTH_LOG2:0]   pcm_level_o,
    input  logic                            ur_clear_i,
    output logic [`UR_COUNT_WIDTH-1:0]      ur_count_o,
    output logic                            ur_flag_o,
    output logic                            bclk_o,
    output logic                            ws_o,
    output logic                            data_o
);
    import pcm_pkg::*;

    pcm_frame_t fifo_data;
    logic       fifo_empty;
    logic       fifo_rd;
    logic       pcm_ur;

    pcm_fifo
    #(
        .DEPTH_LOG2 (`PCM_FIFO_DEPTH_LOG2)
    )
    u_fifo
    (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .wr_i    (pcm_wr_i),
        .data_i  (pcm_data_i),
        .full_o  (pcm_full_o),
        .rd_i    (fifo_rd),
        .data_o  (fifo_data),
        .empty_o (fifo_empty),
        .level_o (pcm_level_o)
    );

    i2s_tx
    #(
        .CLK_DIVISOR (`AUDIO_CLK_DIVISOR)
    )
    u_tx
    (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .pcm_data_i       (fifo_data),
        .pcm_fifo_empty_i (fifo_empty),
        .pcm_fifo_rd_o    (fifo_rd),
        .pcm_fifo_ur_o    (pcm_ur),
        .bclk_o           (bclk_o),
        .ws_o             (ws_o),
        .data_o           (data_o)
    );

    // Underrun strobe is only visible to the host through the monitor
    underrun_monitor
    #(
        .COUNT_WIDTH (`UR_COUNT_WIDTH)
    )
    u_monitor
    (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .ur_i    (pcm_ur),
        .clear_i (ur_clear_i),
        .count_o (ur_count_o),
        .flag_o  (ur_flag_o)
    );

endmodule

//--- rtl/underrun_monitor.sv
`timescale 1ns/100ps
`include "audio_config.svh"

module underrun_monitor
#(
    parameter int COUNT_WIDTH = `UR_COUNT_WIDTH
)
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   ur_i,
    input  logic                   clear_i,
    output logic [COUNT_WIDTH-1:0] count_o,
    output logic                   flag_o
);

    logic count_max;

    assign count_max = &count_o;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            count_o <= '0;
        end
        else if (clear_i)
        begin
            count_o <= '0; // Clear takes priority over a coincident underrun
        end
        else if (ur_i && !count_max)
        begin
            count_o <= count_o + 1'b1;
        end
    end

    // Flag stays set until the host clears it
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            flag_o <= 1'b0;
        end
        else if (clear_i)
        begin
            flag_o <= 1'b0;
        end
        else if (ur_i)
        begin
            flag_o <= 1'b1;
        end
    end

endmodule

//--- rtl/i2s_tx.sv
`timescale 1ns/100ps
`include "audio_config.svh"

module i2s_tx
#(
    parameter int CLK_DIVISOR = `AUDIO_CLK_DIVISOR
)
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  pcm_pkg::pcm_frame_t pcm_data_i,
    input  logic                pcm_fifo_empty_i,
    output logic                pcm_fifo_rd_o,
    output logic                pcm_fifo_ur_o,
    output logic                bclk_o,
    output logic                ws_o,
    output logic                data_o
);
    import pcm_pkg::*;
    import i2s_pkg::*;

    localparam int DIV_W = (CLK_DIVISOR > 1) ? $clog2(CLK_DIVISOR) : 1;
    localparam int CNT_W = $clog2(I2S_BITS_PER_FRAME);

    logic [DIV_W-1:0] clk_div;
    logic             audio_clk;
    logic             audio_clk_q;
    logic             bit_fall;
    logic             bit_rise;
    logic [CNT_W-1:0] bit_cnt;
    i2s_phase_e       phase;
    i2s_slot_e        slot_nxt;
    i2s_slot_e        ws_q;
    pcm_word_t        left_sr;
    pcm_word_t        right_sr;
    pcm_frame_t       last_frame;

    // Internal audio clock toggles every CLK_DIVISOR system clocks
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            clk_div   <= '0;
            audio_clk <= 1'b0;
        end
        else if (clk_div == DIV_W'(CLK_DIVISOR - 1))
        begin
            clk_div   <= '0;
            audio_clk <= ~audio_clk;
        end
        else
        begin
            clk_div <= clk_div + 1'b1;
        end
    end

    assign bit_fall = audio_clk_q & ~audio_clk;
    assign bit_rise = ~audio_clk_q & audio_clk;

    assign phase    = (bit_cnt == '0) ? PH_FETCH : PH_SHIFT;
    assign slot_nxt = bit_cnt[CNT_W-1] ? SLOT_RIGHT : SLOT_LEFT; // Upper half of the frame is right

    // Strobes fire in the detection cycle so they line up with the empty level they decode
    assign pcm_fifo_rd_o = bit_fall && (phase == PH_FETCH) && !pcm_fifo_empty_i;
    assign pcm_fifo_ur_o = bit_fall && (phase == PH_FETCH) && pcm_fifo_empty_i;

    assign ws_o = ws_q;

    // Word select moves one bit ahead of the data, so the word in flight is picked by the old ws
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            audio_clk_q <= 1'b0;
            bclk_o      <= 1'b0;
            bit_cnt     <= '0;
            ws_q        <= SLOT_LEFT;
            data_o      <= 1'b0;
            left_sr     <= '0;
            right_sr    <= '0;
            last_frame  <= '0;
        end
        else
        begin
            audio_clk_q <= audio_clk;
            if (bit_rise)
            begin
                bclk_o <= 1'b1;
            end
            if (bit_fall)
            begin
                bclk_o  <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1; // Wraps at the end of the frame
                ws_q    <= slot_nxt;
                if (ws_q == SLOT_LEFT)
                begin
                    data_o  <= left_sr[PCM_WORD_BITS-1];
                    left_sr <= left_sr << 1;
                end
                else
                begin
                    data_o   <= right_sr[PCM_WORD_BITS-1];
                    right_sr <= right_sr << 1;
                end
                if (phase == PH_FETCH)
                begin
                    // The held frame starts shifting while the new one waits a full frame
                    left_sr  <= last_frame.left;
                    right_sr <= last_frame.right;
                    if (!pcm_fifo_empty_i)
                    begin
                        last_frame <= pcm_data_i;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/pcm_fifo.sv
`timescale 1ns/100ps
`include "audio_config.svh"

module pcm_fifo
#(
    parameter int DEPTH_LOG2 = `PCM_FIFO_DEPTH_LOG2
)
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   wr_i,
    input  pcm_pkg::pcm_frame_t    data_i,
    output logic                   full_o,
    input  logic                   rd_i,
    output pcm_pkg::pcm_frame_t    data_o,
    output logic                   empty_o,
    output logic [DEPTH_LOG2:0]    level_o
);
    import pcm_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    pcm_frame_t            mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr_i & ~full_o;  // Writes into a full buffer are lost
    assign do_rd = rd_i & ~empty_o;

    // Count never exceeds DEPTH, so its top bit alone marks full
    assign full_o  = count[DEPTH_LOG2];
    assign empty_o = (count == '0);
    assign level_o = count;

    // Head frame is visible without a read strobe
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk_i)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the power of two depth
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            count <= '0;
        end
        else
        begin
            case ({do_wr, do_rd})
                2'b10:
                begin
                    count <= count + 1'b1;
                end
                2'b01:
                begin
                    count <= count - 1'b1;
                end
                default:
                begin
                    count <= count; // Both or neither leave the level as it is
                end
            endcase
        end
    end

endmodule

//--- rtl/i2s_pkg.sv
package i2s_pkg;

    localparam int I2S_BITS_PER_FRAME = 32; // Two 16 bit slots

    // Value driven on word select, low is the left channel
    typedef enum logic
    {
        SLOT_LEFT  = 1'b0,
        SLOT_RIGHT = 1'b1
    } i2s_slot_e;

    // Position of the current bit within the frame
    typedef enum logic
    {
        PH_FETCH = 1'b0, // Bit 0 of a left word
        PH_SHIFT = 1'b1
    } i2s_phase_e;

endpackage

//--- rtl/pcm_pkg.sv
package pcm_pkg;

    localparam int PCM_WORD_BITS = 16;

    // One channel sample, sign is left to the source
    typedef logic [PCM_WORD_BITS-1:0] pcm_word_t;

    // Left sits in the upper half so the packed frame matches the host word
    typedef struct packed
    {
        pcm_word_t left;
        pcm_word_t right;
    } pcm_frame_t;

endpackage

//--- rtl/audio_config.svh
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// System clocks per half period of the bit clock
`define AUDIO_CLK_DIVISOR 6

// The frame buffer holds 2**N frames
`define PCM_FIFO_DEPTH_LOG2 4

`define UR_COUNT_WIDTH 8 // Underrun count saturates at all ones

`endif
